// ==== common/manager_pkg.sv ====
// --------------------
// Widths, codes and packed types for the work-unit front end
// Imported by every RTL block and by the testbench
// --------------------
`default_nettype none

package manager_pkg;

  // --------------------
  // Work-unit instruction
  // --------------------
  localparam int INST_TYPE_W  = 2;
  localparam int OPT_PER_INST = 3;   // Option tuples per instruction
  localparam int OPT_TYPE_W   = 4;
  localparam int OPT_VALUE_W  = 8;
  localparam int CNTL_W       = 2;   // Stack interface delineator

  typedef enum logic [INST_TYPE_W-1:0] {
    INST_NOP = 2'd0,
    INST_OP  = 2'd1,  // Only opcode that reaches the OOB port
    INST_MR  = 2'd2,  // Memory read, dropped
    INST_MW  = 2'd3   // Memory write, dropped
  } inst_type_e;

  // Option types, anything above SIMD_CMD is ignored by decode
  typedef enum logic [OPT_TYPE_W-1:0] {
    OPT_NONE      = 4'd0,
    OPT_NUM_LANES = 4'd1,
    OPT_STOP_CMD  = 4'd2,
    OPT_SIMD_CMD  = 4'd3
  } opt_type_e;

  typedef enum logic [CNTL_W-1:0] {
    CNTL_SOM = 2'd1,  // Start of message
    CNTL_MOM = 2'd2,  // Middle of message
    CNTL_EOM = 2'd3   // End of message
  } cntl_e;

  typedef struct packed {
    opt_type_e                opt_type;
    logic [OPT_VALUE_W-1:0]   value;
  } wu_option_t;  // 12 bits

  // One hex word of 10 digits, option 2 in the high bits
  typedef struct packed {
    cntl_e                          cntl;
    inst_type_e                     op;
    wu_option_t [OPT_PER_INST-1:0]  opt;
  } wu_inst_t;  // 40 bits

  // --------------------
  // OOB downstream
  // --------------------
  localparam int TAG_W      = 4;
  localparam int MGR_ID_W   = 4;
  localparam int OOB_DATA_W = 16;
  localparam int OOB_TYPE_W = 2;

  typedef struct packed {
    logic [TAG_W-1:0]        tag;
    logic [OPT_VALUE_W-1:0]  num_lanes;
    logic [OPT_VALUE_W-1:0]  stop_cmd;
    logic [OPT_VALUE_W-1:0]  simd_cmd;
  } oob_cmd_t;  // 28 bits

  typedef enum logic [OOB_TYPE_W-1:0] {
    OOB_LANES = 2'd1,  // Beat 0, id tag and lane count
    OOB_CMD   = 2'd2   // Beat 1, stop and SIMD commands
  } oob_type_e;

  typedef struct packed {
    cntl_e                   cntl;
    oob_type_e               beat_type;
    logic [OOB_DATA_W-1:0]   data;
  } oob_beat_t;  // 20 bits

endpackage

`default_nettype wire

// ==== design/wu_fetch.sv ====
// --------------------
// Work-unit instruction memory with sequential fetch
// Presents one instruction at a time to the decoder while run is high
// --------------------
`timescale 1ns/100ps
`default_nettype none

module wu_fetch #(
  parameter int WU_DEPTH = 16
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   run,         // Start fetching from address 0
  output logic                        inst_valid,
  input  wire logic                   inst_ready,
  output manager_pkg::wu_inst_t       inst
);

  import manager_pkg::*;

  localparam int ADDR_W = (WU_DEPTH > 1) ? $clog2(WU_DEPTH) : 1;
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(WU_DEPTH - 1);

  // --------------------
  // Instruction store
  // --------------------
  wu_inst_t wu_mem [WU_DEPTH];

  initial
  begin
    $readmemh("wu_program.hex", wu_mem);
  end

  // --------------------
  // Address counter
  // --------------------
  logic [ADDR_W-1:0] addr;
  logic              done;      // Past last address, sticky until reset
  logic              rd_issue;

  // Read when output slot is free or being taken this cycle
  assign rd_issue = run && !done && (!inst_valid || inst_ready);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      addr       <= '0;
      done       <= 1'b0;
      inst_valid <= 1'b0;
    end
    else if (rd_issue)
    begin
      inst_valid <= 1'b1;              // Data lands next cycle
      addr       <= addr + 1'b1;
      if (addr == LAST_ADDR)
        done <= 1'b1;                  // Program exhausted
    end
    else if (inst_ready)
      inst_valid <= 1'b0;              // Taken, nothing new behind it
  end

  // Read port, one cycle latency
  always_ff @(posedge clk)
  begin
    if (rd_issue)
      inst <= wu_mem[addr];
  end

endmodule

`default_nettype wire

// ==== design/wu_decode.sv ====
// --------------------
// Work-unit decode into OOB commands
// Keeps OP instructions only and stamps each with a running tag
// --------------------
`timescale 1ns/100ps
`default_nettype none

module wu_decode (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   inst_valid,
  output logic                        inst_ready,
  input  wire manager_pkg::wu_inst_t  inst,
  output logic                        cmd_valid,
  input  wire logic                   cmd_ready,
  output manager_pkg::oob_cmd_t       cmd
);

  import manager_pkg::*;

  logic              inst_take;
  logic              is_op;
  logic [TAG_W-1:0]  tag_cnt;   // Wraps modulo 16
  oob_cmd_t          dec_cmd;

  // One item per stage, accept when output empty or draining
  assign inst_ready = !cmd_valid || cmd_ready;
  assign inst_take  = inst_valid && inst_ready;
  assign is_op      = (inst.op == INST_OP);   // NOP MR MW just dropped

  // --------------------
  // Option scan
  // --------------------
  always_comb
  begin
    dec_cmd     = '0;          // Missing option decodes to 0
    dec_cmd.tag = tag_cnt;
    // Ascending scan so a repeated type keeps its last value
    for (int i = 0; i < OPT_PER_INST; i++)
    begin
      case (inst.opt[i].opt_type)
        OPT_NUM_LANES: dec_cmd.num_lanes = inst.opt[i].value;
        OPT_STOP_CMD:  dec_cmd.stop_cmd  = inst.opt[i].value;
        OPT_SIMD_CMD:  dec_cmd.simd_cmd  = inst.opt[i].value;
        default:       ;                       // NONE and unknown codes
      endcase
    end
  end

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cmd_valid <= 1'b0;
      tag_cnt   <= '0;
    end
    else if (inst_take && is_op)
    begin
      cmd_valid <= 1'b1;
      tag_cnt   <= tag_cnt + 1'b1;   // Next OP gets next tag
    end
    else if (cmd_ready)
      cmd_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (inst_take && is_op)
      cmd <= dec_cmd;
  end

endmodule

`default_nettype wire

// ==== design/cmd_fifo.sv ====
// --------------------
// Synchronous valid/ready FIFO, payload set by type parameter
// Sits between decode and the OOB transmitter
// --------------------
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      in_valid,
  output logic           in_ready,     // Not full
  input  wire payload_t  in_data,
  output logic           out_valid,    // Not empty
  input  wire logic      out_ready,
  output payload_t       out_data
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

  payload_t           fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               wr_en;
  logic               rd_en;

  assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = fifo_mem[rd_ptr];   // Head of queue
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop leaves count alone
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (rd_en && !wr_en)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (wr_en)
      fifo_mem[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

// ==== design/oob_downstream_tx.sv ====
// --------------------
// Stack bus OOB downstream transmitter
// Sends each command as a SOM/LANES beat then an EOM/CMD beat
// --------------------
`timescale 1ns/100ps
`default_nettype none

module oob_downstream_tx (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic [manager_pkg::MGR_ID_W-1:0] mgr_id,
  input  wire logic                            cmd_valid,
  output logic                                 cmd_ready,
  input  wire manager_pkg::oob_cmd_t           cmd,
  output logic                                 oob_valid,
  input  wire logic                            oob_ready,
  output manager_pkg::oob_beat_t               oob_beat
);

  import manager_pkg::*;

  typedef enum logic {
    ST_LANES = 1'b0,   // Beat 0 on the port
    ST_CMD   = 1'b1    // Beat 1 on the port
  } tx_state_e;

  tx_state_e  state;
  logic       busy;    // Command latched, beats pending
  oob_cmd_t   cmd_q;

  // Free, or last beat leaving this cycle
  assign cmd_ready = !busy || (state == ST_CMD && oob_ready);
  assign oob_valid = busy;

  // --------------------
  // Beat sequencer
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      state <= ST_LANES;
    end
    else if (cmd_valid && cmd_ready)
    begin
      busy  <= 1'b1;
      state <= ST_LANES;
    end
    else if (busy && oob_ready)
    begin
      if (state == ST_LANES)
        state <= ST_CMD;
      else
        busy <= 1'b0;    // Packet done
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_valid && cmd_ready)
      cmd_q <= cmd;
  end

  // Beat mux, held stable by cmd_q and state under back-pressure
  always_comb
  begin
    if (state == ST_LANES)
    begin
      oob_beat.cntl      = CNTL_SOM;
      oob_beat.beat_type = OOB_LANES;
      oob_beat.data      = {mgr_id, cmd_q.tag, cmd_q.num_lanes};
    end
    else
    begin
      oob_beat.cntl      = CNTL_EOM;
      oob_beat.beat_type = OOB_CMD;
      oob_beat.data      = {cmd_q.stop_cmd, cmd_q.simd_cmd};
    end
  end

endmodule

`default_nettype wire

// ==== design/manager.sv ====
// --------------------
// Manager work-unit front end, fetch to OOB downstream port
// --------------------
`timescale 1ns/100ps
`default_nettype none

module manager #(
  parameter int WU_DEPTH   = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             run,
  input  wire logic [manager_pkg::MGR_ID_W-1:0] mgr_id,
  output logic                                  oob_valid,
  input  wire logic                             oob_ready,
  output manager_pkg::oob_beat_t                oob_beat
);

  import manager_pkg::*;

  // --------------------
  // Fetch to decode
  logic      inst_valid;
  logic      inst_ready;
  wu_inst_t  inst;

  // Decode to FIFO
  logic      cmd_valid;
  logic      cmd_ready;
  oob_cmd_t  cmd;

  // FIFO to transmitter
  logic      out_valid;
  logic      out_ready;
  oob_cmd_t  out_data;

  wu_fetch #(
    .WU_DEPTH   (WU_DEPTH)
  ) u_wu_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst)
  );

  wu_decode u_wu_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd)
  );

  cmd_fifo #(
    .payload_t  (oob_cmd_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (cmd_valid),
    .in_ready   (cmd_ready),   // Full stalls decode
    .in_data    (cmd),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

  oob_downstream_tx u_oob_downstream_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .mgr_id     (mgr_id),
    .cmd_valid  (out_valid),
    .cmd_ready  (out_ready),
    .cmd        (out_data),
    .oob_valid  (oob_valid),
    .oob_ready  (oob_ready),
    .oob_beat   (oob_beat)
  );

endmodule

`default_nettype wire

// ==== tb/oob_checker.sv ====
// --------------------
// OOB port checker, builds expected beats from the program file
// Compares every accepted beat and checks hold under back-pressure
// --------------------
`timescale 1ns/100ps
`default_nettype none

module oob_checker #(
  parameter int                               WU_DEPTH = 16,
  parameter logic [manager_pkg::MGR_ID_W-1:0] MGR_ID   = 4'h0
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    oob_valid,
  input  wire logic                    oob_ready,
  input  wire manager_pkg::oob_beat_t  oob_beat,
  output int                           value_errs,
  output int                           proto_errs,
  output int                           beats_seen,
  output int                           exp_total
);

  import manager_pkg::*;

  typedef struct packed {
    oob_beat_t  lanes;   // Beat 0
    oob_beat_t  cmd;     // Beat 1
  } beat_pair_t;

  wu_inst_t   prog [WU_DEPTH];
  oob_beat_t  exp_q [$];
  oob_beat_t  exp_beat;
  oob_beat_t  held_beat;
  string      test_name;
  int         proto_cnt;
  bit         load_fail;
  bit         rst_seen;
  bit         first_after_rst;
  bit         hold_pending;     // Beat offered but not taken last edge

  assign proto_errs = proto_cnt + (load_fail ? 1 : 0);

  // --------------------
  // Reference model
  // --------------------
  function automatic beat_pair_t expected_packet(input wu_inst_t w,
                                                 input logic [TAG_W-1:0] tag,
                                                 input logic [MGR_ID_W-1:0] id);
    logic [OPT_VALUE_W-1:0] lanes;
    logic [OPT_VALUE_W-1:0] stop;
    logic [OPT_VALUE_W-1:0] simd;
    beat_pair_t             p;
    lanes = '0;                                  // Missing type gives 0
    stop  = '0;
    simd  = '0;
    for (int i = 0; i < OPT_PER_INST; i++)
    begin
      if (w.opt[i].opt_type == 4'd1)
        lanes = w.opt[i].value;                  // Later tuple overrides
      else if (w.opt[i].opt_type == 4'd2)
        stop = w.opt[i].value;
      else if (w.opt[i].opt_type == 4'd3)
        simd = w.opt[i].value;
    end
    p.lanes.cntl      = CNTL_SOM;
    p.lanes.beat_type = OOB_LANES;
    p.lanes.data      = {id, tag, lanes};
    p.cmd.cntl        = CNTL_EOM;
    p.cmd.beat_type   = OOB_CMD;
    p.cmd.data        = {stop, simd};
    return p;
  endfunction

  // Expected queue in program order, OP only
  initial
  begin : build_expected
    logic [TAG_W-1:0]  tag;
    beat_pair_t        pair;
    tag = '0;
    $readmemh("tb/wu_program.hex", prog);
    for (int a = 0; a < WU_DEPTH; a++)
    begin
      if (prog[a].op === 2'd1)
      begin
        pair = expected_packet(prog[a], tag, MGR_ID);
        exp_q.push_back(pair.lanes);
        exp_q.push_back(pair.cmd);
        tag = tag + 1'b1;
      end
    end
    exp_total = exp_q.size();
    if (exp_total == 0)
    begin
      $display("No OP instruction found in the work-unit program");
      load_fail = 1'b1;
    end
  end

  // --------------------
  // Compare process
  // --------------------
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      if (rst_seen && oob_valid !== 1'b0)
      begin
        $display("oob_valid is high during reset at %0t", $time);
        proto_cnt++;
      end
      rst_seen        <= 1'b1;
      first_after_rst <= 1'b1;
      hold_pending    <= 1'b0;
    end
    else
    begin
      if (first_after_rst && oob_valid !== 1'b0)
      begin
        $display("oob_valid is high in the first cycle after reset");
        proto_cnt++;
      end
      first_after_rst <= 1'b0;
      // Stalled beat must stay put
      if (hold_pending)
      begin
        if (oob_valid !== 1'b1)
        begin
          $display("oob_valid dropped at %0t before the beat was taken", $time);
          proto_cnt++;
        end
        else if (oob_beat !== held_beat)
        begin
          $display("ERR hold_stable exp=%h act=%h", held_beat, oob_beat);
          value_errs++;
        end
      end
      hold_pending <= (oob_valid === 1'b1) && (oob_ready !== 1'b1);
      held_beat    <= oob_beat;
      if (oob_valid === 1'b1 && oob_ready === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Beat %h accepted after all expected packets were sent", oob_beat);
          proto_cnt++;
        end
        else
        begin
          exp_beat  = exp_q.pop_front();
          test_name = $sformatf("packet%0d_beat%0d", beats_seen / 2, beats_seen % 2);
          if (oob_beat !== exp_beat)
          begin
            $display("ERR %s exp=%h act=%h", test_name, exp_beat, oob_beat);
            value_errs++;
          end
          // Tags count packets from 0
          if (beats_seen % 2 == 0 && oob_beat.data[11:8] !== TAG_W'(beats_seen / 2))
          begin
            $display("ERR tag_order exp=%h act=%h", TAG_W'(beats_seen / 2),
                     oob_beat.data[11:8]);
            value_errs++;
          end
        end
        beats_seen++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_manager.sv ====
// --------------------
// Testbench top for the work-unit front end
// Clock, reset, run control, random OOB back-pressure and watchdog
// --------------------
`timescale 1ns/100ps
`default_nettype none

module tb_manager;

  import manager_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RST_CYCLES   = 8;
  localparam int WU_DEPTH     = 16;
  localparam int FIFO_DEPTH   = 4;
  localparam int BEAT_BUDGET  = 20;    // Cycles allowed per beat
  localparam int DRAIN_CYCLES = 40;    // Quiet time to catch stray beats
  localparam int TIMEOUT_CYCLES = WU_DEPTH * 2 * BEAT_BUDGET + RST_CYCLES + DRAIN_CYCLES;
  localparam logic [MGR_ID_W-1:0] MGR_ID = 4'hA;

  logic                 clk;
  logic                 rst_n;
  logic                 run;
  logic [MGR_ID_W-1:0]  mgr_id;
  logic                 oob_valid;
  logic                 oob_ready;
  oob_beat_t            oob_beat;

  int                   seed;
  int                   value_errs;
  int                   proto_errs;
  int                   beats_seen;
  int                   exp_total;

  manager #(
    .WU_DEPTH   (WU_DEPTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .mgr_id     (mgr_id),
    .oob_valid  (oob_valid),
    .oob_ready  (oob_ready),
    .oob_beat   (oob_beat)
  );

  oob_checker #(
    .WU_DEPTH   (WU_DEPTH),
    .MGR_ID     (MGR_ID)
  ) u_oob_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .oob_valid  (oob_valid),
    .oob_ready  (oob_ready),
    .oob_beat   (oob_beat),
    .value_errs (value_errs),
    .proto_errs (proto_errs),
    .beats_seen (beats_seen),
    .exp_total  (exp_total)
  );

  // --------------------
  // Clock
  // --------------------
  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // OOB ready, mostly high with stall runs long enough to fill the FIFO
  initial
  begin : ready_gen
    int           stall_left;
    logic [31:0]  r;
    seed       = 32'h6df8_e6fd;
    stall_left = 0;
    oob_ready  = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(posedge clk);
      r = $random(seed);
      if (stall_left > 0)
      begin
        oob_ready  <= 1'b0;
        stall_left = stall_left - 1;
      end
      else if (r[3:0] == 4'd0)
      begin
        oob_ready  <= 1'b0;
        stall_left = 6 + int'(r[6:4]);   // Run of 6 to 13 low cycles
      end
      else
        oob_ready <= r[8] | r[9];        // About 3 in 4 high
    end
  end

  // --------------------
  // Run control
  // --------------------
  initial
  begin
    rst_n  = 1'b0;
    run    = 1'b0;
    mgr_id = MGR_ID;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    run <= 1'b1;                         // Fetch starts at address 0
    wait (beats_seen >= exp_total);
    repeat (DRAIN_CYCLES) @(posedge clk);
    $display("Errors: value %0d, protocol %0d; beats %0d of %0d",
             value_errs, proto_errs, beats_seen, exp_total);
    if (value_errs == 0 && proto_errs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d beats seen; value errors %0d, protocol %0d",
             TIMEOUT_CYCLES, beats_seen, exp_total, value_errs, proto_errs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/wu_program.hex ====
// Work-unit program, one 40-bit word per line: cntl/op digit,
// then options 2, 1, 0, each a type digit and two value digits
5322211108  // OP all three options
4000000000  // NOP
5000304110  // OP stop missing
6123456789  // MR dropped
5107105102  // OP num_lanes repeated, last wins
5F442337AA  // OP unknown types
7311222333  // MW dropped
5000000000  // OP all NONE
5301255140  // OP
4000000000  // NOP
5103220210  // OP stop repeated
6000000000  // MR dropped
53FF2EE1DD  // OP all options high values
5912034356  // OP unknown and NONE
7000000000  // MW dropped
D108207306  // OP with EOM cntl

// ==== manager.f ====
common/manager_pkg.sv
design/wu_fetch.sv
design/wu_decode.sv
design/cmd_fifo.sv
design/oob_downstream_tx.sv
design/manager.sv
tb/oob_checker.sv
tb/tb_manager.sv

// ==== Makefile ====
# Verilator build and run of the manager front end testbench
TOP := tb_manager

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, log to sim.log"
	@echo "  clean  remove build output, log and program copy"

test:
	verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f manager.f -o V$(TOP)
	cp tb/wu_program.hex wu_program.hex
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log wu_program.hex
